// ==== tdc_pkg.sv ====
package tdc_pkg;

    // ------------------------------------------------
    // widths
    // ------------------------------------------------
    localparam int TOF_W    = 15;               // full time-of-flight code
    localparam int FINE_W   = 4;                // fine phase bits
    localparam int COARSE_W = TOF_W - FINE_W;   // clock cycles since start
    localparam int PHASE_W  = 16;               // delay-line taps
    localparam int SPAD_W   = 16;               // 4x4 spad enables
    localparam int INT_W    = 4;                // intensity code
    localparam int NUM_W    = 2;                // hit count field

    // sent when the window closes without a single hit
    localparam logic [TOF_W-1:0] TOF_NO_HIT = '1;

    // ------------------------------------------------
    // records
    // ------------------------------------------------
    // one hit as captured inside the window
    typedef struct packed {
        logic [COARSE_W-1:0] coarse;   // counter value at the hit
        logic [PHASE_W-1:0]  phase;    // thermometer phase word
        logic [SPAD_W-1:0]   spad;     // enable pattern at the hit
    } hit_rec_t;

    // one beat of the result burst
    typedef struct packed {
        logic [TOF_W-1:0] tof;
        logic [INT_W-1:0] intensity;
        logic [NUM_W-1:0] num;         // hits in this burst
        logic             last;        // final beat of the burst
    } out_beat_t;

endpackage

// ==== tdc_hit_capture.sv ====
`timescale 1ns/1ps

module tdc_hit_capture
    import tdc_pkg::*;
#(
    parameter int MAX_HITS = 3
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start_i,
    input  logic                       hit_i,
    input  logic [TOF_W-1:0]           range_i,
    input  logic [PHASE_W-1:0]         phase_i,
    input  logic [SPAD_W-1:0]          spad_i,
    input  logic                       burst_done_i,
    output hit_rec_t [MAX_HITS-1:0]    hits_o,
    output logic [NUM_W-1:0]           num_hits_o,
    output logic                       capture_done_o,
    output logic                       busy_o
);

    logic [COARSE_W-1:0] range_q;   // coarse limit latched at start
    logic [COARSE_W-1:0] cnt_q;
    logic [COARSE_W-1:0] cnt_nxt;
    logic                win_q;     // measurement window open
    logic                last_q;    // counter sits on the limit
    logic                busy_q;
    logic                done_q;
    logic [NUM_W-1:0]    num_q;
    hit_rec_t [MAX_HITS-1:0] hits_q;

    logic start_ok;
    logic hit_take;

    assign start_ok = start_i & ~busy_q;   // start while busy is dropped
    assign hit_take = win_q & hit_i & (num_q < MAX_HITS);
    assign cnt_nxt  = cnt_q + 1'b1;

    // ------------------------------------------------
    // busy from start until the burst has gone out
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (start_ok) begin
            busy_q <= 1'b1;
        end else if (burst_done_i) begin
            busy_q <= 1'b0;
        end
    end

    // ------------------------------------------------
    // window and coarse counter
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_q   <= 1'b0;
            last_q  <= 1'b0;
            done_q  <= 1'b0;
            cnt_q   <= '0;
            range_q <= '0;
        end else begin
            done_q <= win_q & last_q;   // one cycle after the last window cycle
            if (start_ok) begin
                win_q   <= 1'b1;
                cnt_q   <= '0;
                range_q <= range_i[TOF_W-1 -: COARSE_W];
                last_q  <= (range_i[TOF_W-1 -: COARSE_W] == '0);
            end else if (win_q) begin
                cnt_q  <= cnt_nxt;
                // compare one step ahead so the end flag is a register
                last_q <= (cnt_nxt == range_q);
                if (last_q) begin
                    win_q <= 1'b0;
                end
            end
        end
    end

    // hit count, saturates at MAX_HITS
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_q <= '0;
        end else if (start_ok) begin
            num_q <= '0;
        end else if (hit_take) begin
            num_q <= num_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_take) begin
            hits_q[num_q].coarse <= cnt_q;
            hits_q[num_q].phase  <= phase_i;
            hits_q[num_q].spad   <= spad_i;
        end
    end

    assign hits_o         = hits_q;
    assign num_hits_o     = num_q;
    assign capture_done_o = done_q;
    assign busy_o         = busy_q;

endmodule

// ==== tdc_tof_calc.sv ====
`timescale 1ns/1ps

module tdc_tof_calc
    import tdc_pkg::*;
#(
    parameter int MAX_HITS = 3
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  hit_rec_t [MAX_HITS-1:0]           hits_i,
    input  logic [NUM_W-1:0]                  num_hits_i,
    input  logic                              start_i,
    output logic [MAX_HITS-1:0][TOF_W-1:0]    tof_o,
    output logic                              done_o
);

    logic                             run_q;
    logic                             done_q;
    logic [NUM_W-1:0]                 idx_q;
    logic [MAX_HITS-1:0][TOF_W-1:0]   tof_q;
    logic                             last_hit;

    // run of ones from tap 0 upward, 16 taps clipped to 15
    function automatic logic [FINE_W-1:0] therm_fine(input logic [PHASE_W-1:0] ph);
        logic [FINE_W:0] n;
        logic            run;
        n   = '0;
        run = 1'b1;
        for (int i = 0; i < PHASE_W; i++) begin
            run = run & ph[i];
            n   = n + (FINE_W+1)'(run);
        end
        return n[FINE_W] ? '1 : n[FINE_W-1:0];
    endfunction

    assign last_hit = (idx_q == num_hits_i - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            idx_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                idx_q  <= '0;
                run_q  <= (num_hits_i != '0);
                done_q <= (num_hits_i == '0);   // nothing to decode
            end else if (run_q) begin
                idx_q <= idx_q + 1'b1;
                if (last_hit) begin
                    run_q  <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // one hit per cycle, coarse on top of fine
    always_ff @(posedge clk) begin
        if (run_q) begin
            tof_q[idx_q] <= {hits_i[idx_q].coarse, therm_fine(hits_i[idx_q].phase)};
        end
    end

    assign tof_o  = tof_q;
    assign done_o = done_q;

endmodule

// ==== tdc_int_calc.sv ====
`timescale 1ns/1ps

module tdc_int_calc
    import tdc_pkg::*;
#(
    parameter int MAX_HITS = 3
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  hit_rec_t [MAX_HITS-1:0]           hits_i,
    input  logic [NUM_W-1:0]                  num_hits_i,
    input  logic                              start_i,
    output logic [MAX_HITS-1:0][INT_W-1:0]    int_o,
    output logic                              done_o
);

    localparam int SLICE_W = 4;                  // enables counted per cycle
    localparam int STEPS   = SPAD_W / SLICE_W;
    localparam int PART_W  = $clog2(STEPS);
    localparam int ACC_W   = $clog2(SPAD_W + 1);

    logic                             run_q;
    logic                             done_q;
    logic [NUM_W-1:0]                 idx_q;
    logic [PART_W-1:0]                part_q;    // slice within the spad word
    logic [ACC_W-1:0]                 acc_q;
    logic [MAX_HITS-1:0][INT_W-1:0]   int_q;

    logic [SLICE_W-1:0] slice;
    logic [ACC_W-1:0]   sum;
    logic               last_part;
    logic               last_hit;

    assign slice     = hits_i[idx_q].spad[part_q*SLICE_W +: SLICE_W];
    assign last_part = (part_q == PART_W'(STEPS - 1));
    assign last_hit  = (idx_q == num_hits_i - 1'b1);

    always_comb begin
        sum = acc_q;
        for (int i = 0; i < SLICE_W; i++) begin
            sum = sum + ACC_W'(slice[i]);
        end
    end

    // ------------------------------------------------
    // sequencing over hits and slices
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            idx_q  <= '0;
            part_q <= '0;
            acc_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                idx_q  <= '0;
                part_q <= '0;
                acc_q  <= '0;
                run_q  <= (num_hits_i != '0);
                done_q <= (num_hits_i == '0);
            end else if (run_q) begin
                part_q <= part_q + 1'b1;
                acc_q  <= last_part ? '0 : sum;
                if (last_part) begin
                    idx_q <= idx_q + 1'b1;
                    if (last_hit) begin
                        run_q  <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

    // store with saturation at 15
    always_ff @(posedge clk) begin
        if (run_q && last_part) begin
            int_q[idx_q] <= (sum > ACC_W'(2**INT_W - 1)) ? '1 : sum[INT_W-1:0];
        end
    end

    assign int_o  = int_q;
    assign done_o = done_q;

endmodule

// ==== tdc_out_stream.sv ====
`timescale 1ns/1ps

module tdc_out_stream
    import tdc_pkg::*;
#(
    parameter int MAX_HITS = 3
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [MAX_HITS-1:0][TOF_W-1:0]    tof_i,
    input  logic [MAX_HITS-1:0][INT_W-1:0]    int_i,
    input  logic [NUM_W-1:0]                  num_hits_i,
    input  logic                              tof_done_i,
    input  logic                              int_done_i,
    input  logic                              ready_i,
    output out_beat_t                         beat_o,
    output logic                              valid_o,
    output logic                              burst_done_o
);

    // one-hot state encoding
    localparam logic [2:0] ST_IDLE = 3'b001;
    localparam logic [2:0] ST_WAIT = 3'b010;   // one engine reported
    localparam logic [2:0] ST_SEND = 3'b100;

    logic [2:0]       state_q;
    logic [NUM_W-1:0] idx_q;      // beat index within the burst
    logic             tof_seen_q;
    logic             int_seen_q;

    logic both_ok;
    logic send;
    logic fire;
    logic last_beat;

    // a done pulse counts in the cycle it arrives
    assign both_ok   = (tof_seen_q | tof_done_i) & (int_seen_q | int_done_i);
    assign send      = (state_q == ST_SEND);
    assign fire      = send & ready_i;
    assign last_beat = (num_hits_i == '0) || (idx_q == num_hits_i - 1'b1);

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            idx_q      <= '0;
            tof_seen_q <= 1'b0;
            int_seen_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE, ST_WAIT: begin
                    if (both_ok) begin
                        state_q    <= ST_SEND;
                        idx_q      <= '0;
                        tof_seen_q <= 1'b0;
                        int_seen_q <= 1'b0;
                    end else begin
                        tof_seen_q <= tof_seen_q | tof_done_i;
                        int_seen_q <= int_seen_q | int_done_i;
                        if (tof_done_i || int_done_i) begin
                            state_q <= ST_WAIT;
                        end
                    end
                end
                ST_SEND: begin
                    if (fire) begin
                        if (last_beat) begin
                            state_q <= ST_IDLE;
                        end else begin
                            idx_q <= idx_q + 1'b1;   // next beat right away
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // beat picked by the index holds while stalled
    always_comb begin
        beat_o.num  = num_hits_i;
        beat_o.last = send & last_beat;
        if (num_hits_i == '0) begin
            beat_o.tof       = TOF_NO_HIT;
            beat_o.intensity = '0;
        end else begin
            beat_o.tof       = tof_i[idx_q];
            beat_o.intensity = int_i[idx_q];
        end
    end

    assign valid_o      = send;
    assign burst_done_o = fire & last_beat;   // releases busy

endmodule

// ==== tdc_top.sv ====
`timescale 1ns/1ps

module tdc_top
    import tdc_pkg::*;
#(
    parameter int MAX_HITS = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  logic                 hit_i,
    input  logic [TOF_W-1:0]     range_i,
    input  logic [PHASE_W-1:0]   phase_i,
    input  logic [SPAD_W-1:0]    spad_i,
    input  logic                 ready_i,
    output out_beat_t            beat_o,
    output logic                 valid_o,
    output logic                 busy_o
);

    hit_rec_t [MAX_HITS-1:0]           hits;
    logic [NUM_W-1:0]                  num_hits;
    logic                              capture_done;
    logic [MAX_HITS-1:0][TOF_W-1:0]    tof;
    logic [MAX_HITS-1:0][INT_W-1:0]    intensity;
    logic                              tof_done;
    logic                              int_done;
    logic                              burst_done;

    // ------------------------------------------------
    // capture, two engines in parallel, streamer
    // ------------------------------------------------
    tdc_hit_capture #(.MAX_HITS(MAX_HITS)) u_capture (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .hit_i          (hit_i),
        .range_i        (range_i),
        .phase_i        (phase_i),
        .spad_i         (spad_i),
        .burst_done_i   (burst_done),
        .hits_o         (hits),
        .num_hits_o     (num_hits),
        .capture_done_o (capture_done),
        .busy_o         (busy_o)
    );

    tdc_tof_calc #(.MAX_HITS(MAX_HITS)) u_tof (
        .clk        (clk),
        .rst_n      (rst_n),
        .hits_i     (hits),
        .num_hits_i (num_hits),
        .start_i    (capture_done),
        .tof_o      (tof),
        .done_o     (tof_done)
    );

    tdc_int_calc #(.MAX_HITS(MAX_HITS)) u_int (
        .clk        (clk),
        .rst_n      (rst_n),
        .hits_i     (hits),
        .num_hits_i (num_hits),
        .start_i    (capture_done),
        .int_o      (intensity),
        .done_o     (int_done)
    );

    tdc_out_stream #(.MAX_HITS(MAX_HITS)) u_stream (
        .clk          (clk),
        .rst_n        (rst_n),
        .tof_i        (tof),
        .int_i        (intensity),
        .num_hits_i   (num_hits),
        .tof_done_i   (tof_done),
        .int_done_i   (int_done),
        .ready_i      (ready_i),
        .beat_o       (beat_o),
        .valid_o      (valid_o),
        .burst_done_o (burst_done)
    );

endmodule

// ==== tdc_properties.sv ====
`timescale 1ns/1ps

module tdc_properties
    import tdc_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      start_i,
    input logic      ready_i,
    input logic      valid_o,
    input logic      busy_o,
    input out_beat_t beat_o
);

    int fail_cnt = 0;   // failed assertions so far

    // ------------------------------------------------
    // output handshake
    // ------------------------------------------------
    // a stalled beat keeps valid and data
    hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o && !ready_i |=> valid_o && $stable(beat_o))
    else begin
        fail_cnt++;
        $error("beat_o changed or valid_o dropped while stalled");
    end

    last_a: assert property (@(posedge clk) disable iff (!rst_n)
        beat_o.last |-> valid_o)
    else begin
        fail_cnt++;
        $error("beat_o.last high without valid_o");
    end

    // ------------------------------------------------
    // busy
    // ------------------------------------------------
    busy_a: assert property (@(posedge clk) disable iff (!rst_n)
        start_i && !busy_o |=> busy_o)
    else begin
        fail_cnt++;
        $error("busy_o did not rise after start_i while idle");
    end

    valid_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> busy_o)   // burst belongs to a measurement
    else begin
        fail_cnt++;
        $error("valid_o high while busy_o low");
    end

endmodule

bind tdc_top tdc_properties u_props (.*);

// ==== tb_tdc.sv ====
`timescale 1ns/1ps

module tb_tdc
    import tdc_pkg::*;
();

    localparam int MAX_HITS    = 3;
    localparam int NUM_TESTS   = 5;
    localparam int WIN_MAX     = 300;   // longest window plus engine latency
    localparam int BURST_MAX   = 200;   // burst under random stalls
    localparam int CYCLE_LIMIT = NUM_TESTS * (WIN_MAX + BURST_MAX) * 8;

    logic               clk;
    logic               rst_n;
    logic               start_i;
    logic               hit_i;
    logic [TOF_W-1:0]   range_i;
    logic [PHASE_W-1:0] phase_i;
    logic [SPAD_W-1:0]  spad_i;
    logic               ready_i;
    out_beat_t          beat_o;
    logic               valid_o;
    logic               busy_o;

    integer             seed = 32'h998d;
    int                 cycles;
    int                 err_cnt;
    int                 pass_cnt;
    int                 fail_cnt;
    bit                 stall_en;
    int                 hit_cyc[$];     // coarse position of each planned hit
    logic [PHASE_W-1:0] hit_phase[$];
    logic [SPAD_W-1:0]  hit_spad[$];
    out_beat_t          exp_q[$];       // beats still to come

    tdc_top #(.MAX_HITS(MAX_HITS)) tdc_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .hit_i   (hit_i),
        .range_i (range_i),
        .phase_i (phase_i),
        .spad_i  (spad_i),
        .ready_i (ready_i),
        .beat_o  (beat_o),
        .valid_o (valid_o),
        .busy_o  (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------
    // reference rules
    // ------------------------------------------------
    function automatic logic [FINE_W-1:0] fine_of(input logic [PHASE_W-1:0] ph);
        int n;
        n = 0;
        while (n < PHASE_W && ph[n]) n++;   // ones from tap 0 up
        return (n > 2**FINE_W - 1) ? '1 : FINE_W'(n);
    endfunction

    function automatic logic [INT_W-1:0] ones_of(input logic [SPAD_W-1:0] sp);
        int n;
        n = $countones(sp);
        return (n > 2**INT_W - 1) ? '1 : INT_W'(n);
    endfunction

    function automatic logic [PHASE_W-1:0] rand_therm();
        int k;
        k = $unsigned($random(seed)) % (PHASE_W + 1);
        return PHASE_W'((32'h1 << k) - 1);
    endfunction

    function automatic int total_errors();
        return err_cnt + tdc_top_i.u_props.fail_cnt;
    endfunction

    always @(posedge clk) begin
        if (stall_en) begin
            ready_i <= ($unsigned($random(seed)) % 3) != 0;
        end else begin
            ready_i <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d beats missing", cycles, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        assert (act_v == exp_v) else begin
            $display("ERROR: %s expected %h got %h", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    // beat accepted at the next rising edge
    always @(negedge clk) begin
        out_beat_t e;
        if (rst_n && valid_o && ready_i) begin
            assert (exp_q.size() > 0) else begin
                $display("beat transferred when no beat was expected");
                err_cnt++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                compare_value("beat_o.tof", e.tof, beat_o.tof);
                compare_value("beat_o.intensity", e.intensity, beat_o.intensity);
                compare_value("beat_o.num", e.num, beat_o.num);
                compare_value("beat_o.last", e.last, beat_o.last);
                compare_value("busy_o", 1, busy_o);
            end
        end
    end

    // ------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------
    task automatic add_hit(input int c, input logic [PHASE_W-1:0] ph,
                           input logic [SPAD_W-1:0] sp);
        hit_cyc.push_back(c);
        hit_phase.push_back(ph);
        hit_spad.push_back(sp);
    endtask

    task automatic run_window(input int rng);
        int c;
        int k;
        int n;
        n = (hit_cyc.size() < MAX_HITS) ? hit_cyc.size() : MAX_HITS;
        for (k = 0; k < n; k++) begin
            exp_q.push_back('{tof: {COARSE_W'(hit_cyc[k]), fine_of(hit_phase[k])},
                              intensity: ones_of(hit_spad[k]),
                              num: NUM_W'(n), last: (k == n - 1)});
        end
        if (n == 0) begin
            exp_q.push_back('{tof: TOF_NO_HIT, intensity: INT_W'(0), num: NUM_W'(0),
                              last: 1'b1});
        end
        @(posedge clk);
        start_i <= 1'b1;
        range_i <= {COARSE_W'(rng), FINE_W'($random(seed))};   // fine bits unused
        @(posedge clk);
        start_i <= 1'b0;
        k = 0;
        for (c = 0; c <= rng; c++) begin   // c is the coarse count the DUT sees
            if (k < hit_cyc.size() && hit_cyc[k] == c) begin
                hit_i   <= 1'b1;
                phase_i <= hit_phase[k];
                spad_i  <= hit_spad[k];
                k++;
            end else begin
                hit_i   <= 1'b0;
                phase_i <= rand_therm();
                spad_i  <= SPAD_W'($random(seed));
            end
            @(posedge clk);
        end
        hit_i <= 1'b0;
        hit_cyc.delete();
        hit_phase.delete();
        hit_spad.delete();
    endtask

    task automatic finish_burst();
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
        assert (!busy_o) else begin
            $display("busy_o still high after the last beat transferred");
            err_cnt++;
        end
    endtask

    task automatic log_result(input string name, input int errs_before);
        if (total_errors() == errs_before) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, total_errors() - errs_before);
        end
    endtask

    initial begin
        int e0;
        rst_n    = 1'b0;
        start_i  = 1'b0;
        hit_i    = 1'b0;
        range_i  = '0;
        phase_i  = '0;
        spad_i   = '0;
        ready_i  = 1'b1;
        stall_en = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!valid_o && !busy_o) else begin
            $display("valid_o or busy_o high after reset");
            err_cnt++;
        end

        e0 = total_errors();
        run_window(4);
        finish_burst();
        log_result("zero_hits", e0);

        e0 = total_errors();
        add_hit(5, rand_therm(), SPAD_W'($random(seed)));
        add_hit(17, rand_therm(), SPAD_W'($random(seed)));
        run_window(40);
        finish_burst();
        log_result("two_hits", e0);

        e0 = total_errors();
        stall_en = 1'b1;
        add_hit(2, rand_therm(), SPAD_W'($random(seed)));
        add_hit(9, rand_therm(), SPAD_W'($random(seed)));
        add_hit(10, rand_therm(), SPAD_W'($random(seed)));
        add_hit(30, rand_therm(), SPAD_W'($random(seed)));   // dropped
        add_hit(55, rand_therm(), SPAD_W'($random(seed)));   // dropped
        run_window(60);
        finish_burst();
        log_result("five_hits", e0);

        e0 = total_errors();
        stall_en = 1'b0;
        add_hit(1, rand_therm(), 16'h0421);
        add_hit(3, rand_therm(), 16'hffff);
        add_hit(8, rand_therm(), 16'h0000);
        run_window(20);
        finish_burst();
        log_result("intensity", e0);

        // last hit sits on the final window cycle
        e0 = total_errors();
        stall_en = 1'b1;
        add_hit(0, rand_therm(), SPAD_W'($random(seed)));
        add_hit(50, rand_therm(), SPAD_W'($random(seed)));
        add_hit(100, rand_therm(), SPAD_W'($random(seed)));
        run_window(100);
        while (!valid_o) @(negedge clk);
        @(posedge clk);
        start_i <= 1'b1;   // ignored, burst still pending
        @(posedge clk);
        start_i <= 1'b0;
        finish_burst();
        log_result("backpressure", e0);

        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tdc.f ====
tdc_pkg.sv
tdc_hit_capture.sv
tdc_tof_calc.sv
tdc_int_calc.sv
tdc_out_stream.sv
tdc_top.sv
tdc_properties.sv
tb_tdc.sv

// ==== Bender.yml ====
package:
  name: tdc

sources:
  - tdc_pkg.sv
  - tdc_hit_capture.sv
  - tdc_tof_calc.sv
  - tdc_int_calc.sv
  - tdc_out_stream.sv
  - tdc_top.sv
  - target: test
    files:
      - tdc_properties.sv
      - tb_tdc.sv
